//--- common/ahb_pkg.sv
package ahb_pkg;

    localparam int AHB_AW = 32;                 // haddr width
    localparam int AHB_DW = 32;                 // hwdata / hrdata width

    // transfer type
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,                  // no transfer
        HTRANS_BUSY   = 2'b01,                  // master inserts idle in burst
        HTRANS_NONSEQ = 2'b10,                  // single or first transfer
        HTRANS_SEQ    = 2'b11                   // following transfer
    } htrans_t;

    // transfer size
    typedef enum logic [2:0] {
        HSIZE_B  = 3'b000,                      // byte
        HSIZE_HW = 3'b001,                      // halfword
        HSIZE_W  = 3'b010                       // word
    } hsize_t;

    // slave response
    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_t;

    // control taken in address phase, used in data phase
    typedef struct packed {
        logic                valid_write;       // accepted write pending
        hsize_t              size;              // registered hsize
        logic [AHB_AW-1:0]   addr;              // registered byte address
    } dphase_ctrl_t;

    // default slave two-cycle error sequence
    typedef enum logic [1:0] {
        ERR_IDLE   = 2'b00,                     // no error data phase
        ERR_FIRST  = 2'b01,                     // error, hready low
        ERR_SECOND = 2'b10                      // error, hready high
    } err_state_t;

endpackage : ahb_pkg

//--- common/mem_map_pkg.sv
package mem_map_pkg;

    localparam int NUM_BANKS    = 4;            // ram banks on the bus
    localparam int BANK_WORDS   = 256;          // words per bank
    localparam int BANK_AW      = 8;            // word address width
    localparam int BANK_SEL_LSB = 10;           // bank field low bit
    localparam int BANK_SEL_W   = 2;            // bank field width

    // everything from here up goes to the default slave
    localparam logic [31:0] MAP_LIMIT = 32'h0000_1000;

    typedef logic [BANK_SEL_W-1:0] bank_idx_t; // bank number

endpackage : mem_map_pkg

//--- common/ahb_slave_if.sv
`timescale 1ns/1ps

interface ahb_slave_if;

    import ahb_pkg::*;

    // address phase, from decoder
    logic                hsel;              // bank select
    logic [AHB_AW-1:0]   haddr;             // byte address
    logic                hwrite;            // 1 = write
    htrans_t             htrans;            // transfer type
    hsize_t              hsize;             // transfer size
    logic [AHB_DW-1:0]   hwdata;            // write data, data phase
    logic                hready;            // global hready from mux
    // data phase, from slave
    logic [AHB_DW-1:0]   hrdata;            // read data
    logic                hreadyout;         // slave ready
    hresp_t              hresp;             // slave response

    modport master (
        output hsel, haddr, hwrite, htrans, hsize, hwdata, hready,
        input  hrdata, hreadyout, hresp
    );

    modport slave (
        input  hsel, haddr, hwrite, htrans, hsize, hwdata, hready,
        output hrdata, hreadyout, hresp
    );

endinterface : ahb_slave_if

//--- common/ram_port_if.sv
`timescale 1ns/1ps

interface ram_port_if;

    import mem_map_pkg::*;

    logic [BANK_AW-1:0]  addr;              // word address
    logic [31:0]         wd;                // write data
    logic [31:0]         rd;                // read data
    logic [3:0]          we;                // byte lane write enables

    modport bridge (
        output addr, wd, we,
        input  rd
    );

    modport memory (
        input  addr, wd, we,
        output rd
    );

endinterface : ram_port_if

//--- design/ahb_addr_decoder.sv
`timescale 1ns/1ps

module ahb_addr_decoder (
    input  logic [ahb_pkg::AHB_AW-1:0]  haddr,          // master address
    input  ahb_pkg::htrans_t            htrans,         // master transfer type
    input  logic                        hwrite,         // master direction
    input  ahb_pkg::hsize_t             hsize,          // master size
    input  logic [ahb_pkg::AHB_DW-1:0]  hwdata,         // master write data
    input  logic                        hready,         // global ready from mux
    ahb_slave_if.master                 slv [mem_map_pkg::NUM_BANKS], // bank buses
    output logic                        unmapped_sel,   // default slave select
    output logic                        addr_phase      // transfer accepted this edge
);

    import ahb_pkg::*;
    import mem_map_pkg::*;

    logic       mapped;                     // address below map limit
    bank_idx_t  bank_field;                 // haddr bank bits

    assign mapped       = (haddr < MAP_LIMIT);
    assign unmapped_sel = !mapped;          // out of range -> default slave
    assign bank_field   = haddr[BANK_SEL_LSB +: BANK_SEL_W];

    // nonseq or seq with hready high is a real transfer
    assign addr_phase = hready &&
                        ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_fanout
        assign slv[i].hsel   = mapped && (bank_field == bank_idx_t'(i)); // one-hot
        assign slv[i].haddr  = haddr;       // shared address phase
        assign slv[i].hwrite = hwrite;
        assign slv[i].htrans = htrans;
        assign slv[i].hsize  = hsize;
        assign slv[i].hwdata = hwdata;      // shared data phase
        assign slv[i].hready = hready;      // every slave sees bus ready
    end

endmodule : ahb_addr_decoder

//--- ahb_ram/ahb_ram_bridge.sv
`timescale 1ns/1ps

module ahb_ram_bridge (
    input  logic            hclk,           // bus clock
    input  logic            reset,          // sync, active high
    ahb_slave_if.slave      slv,            // ahb side
    ram_port_if.bridge      ram             // memory side
);

    import ahb_pkg::*;
    import mem_map_pkg::*;

    dphase_ctrl_t   ctrl;                   // registered address phase
    logic           accept;                 // address phase taken by this bank
    logic [3:0]     lane_we;                // lanes hit by size and address

    assign accept = slv.hsel && slv.hready &&
                    ((slv.htrans == HTRANS_NONSEQ) || (slv.htrans == HTRANS_SEQ));

    // capture control on every bus-ready edge
    always_ff @(posedge hclk) begin
        if (reset) begin
            ctrl <= '0;                     // no pending write
        end else if (slv.hready) begin
            ctrl.valid_write <= accept && slv.hwrite; // drops after one data phase
            if (accept) begin
                ctrl.size <= slv.hsize;
                ctrl.addr <= slv.haddr;     // also the read address
            end
        end
    end

    // byte lane rules
    always_comb begin
        lane_we = 4'b0000;
        case (ctrl.size)
            HSIZE_W: begin
                lane_we = 4'b1111;          // whole word
            end
            HSIZE_HW: begin
                if (ctrl.addr[1]) begin
                    lane_we = 4'b1100;      // upper half
                end else begin
                    lane_we = 4'b0011;      // lower half
                end
            end
            HSIZE_B: begin
                case (ctrl.addr[1:0])
                    2'b00:   lane_we = 4'b0001;
                    2'b01:   lane_we = 4'b0010;
                    2'b10:   lane_we = 4'b0100;
                    default: lane_we = 4'b1000;
                endcase
            end
            default: begin
                lane_we = 4'b0000;          // wider sizes not supported
            end
        endcase
    end

    assign ram.we   = ctrl.valid_write ? lane_we : 4'b0000; // writes only
    assign ram.addr = ctrl.addr[2 +: BANK_AW];              // byte -> word address
    assign ram.wd   = slv.hwdata;           // hwdata arrives in data phase

    assign slv.hrdata    = ram.rd;          // async read of registered address
    assign slv.hreadyout = 1'b1;            // zero wait
    assign slv.hresp     = HRESP_OKAY;      // ram never errors

endmodule : ahb_ram_bridge

//--- ahb_ram/ram_bank_mem.sv
`timescale 1ns/1ps

module ram_bank_mem (
    input  logic            hclk,           // bus clock
    ram_port_if.memory      ram             // port from bridge
);

    import mem_map_pkg::*;

    logic [3:0][7:0] mem [BANK_WORDS];      // four byte lanes per word

    // each lane written on its own enable
    always_ff @(posedge hclk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (ram.we[lane]) begin
                mem[ram.addr][lane] <= ram.wd[8*lane +: 8];
            end
        end
    end

    // read straight from the array
    assign ram.rd = mem[ram.addr];          // addr is already registered

endmodule : ram_bank_mem

//--- design/ahb_resp_mux.sv
`timescale 1ns/1ps

module ahb_resp_mux (
    input  logic                        hclk,           // bus clock
    input  logic                        reset,          // sync, active high
    ahb_slave_if.master                 slv [mem_map_pkg::NUM_BANKS], // bank responses
    input  logic                        unmapped_sel,   // address is out of map
    input  logic                        addr_phase,     // transfer accepted
    output logic [ahb_pkg::AHB_DW-1:0]  hrdata,         // merged read data
    output logic                        hready,         // merged ready
    output ahb_pkg::hresp_t             hresp           // merged response
);

    import ahb_pkg::*;
    import mem_map_pkg::*;

    err_state_t             err_state;              // default slave state
    err_state_t             err_next;
    bank_idx_t              sel_idx;                // bank addressed now
    bank_idx_t              owner_idx;              // bank in data phase
    logic                   err_owner;              // default slave owns data phase
    logic [NUM_BANKS-1:0]   bank_sel;               // hsel per bank
    logic [NUM_BANKS-1:0]   bank_ready;             // hreadyout per bank
    logic [AHB_DW-1:0]      bank_rdata [NUM_BANKS];
    hresp_t                 bank_resp  [NUM_BANKS];

    // flatten the interface array for variable indexing
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_flat
        assign bank_sel[i]   = slv[i].hsel;
        assign bank_ready[i] = slv[i].hreadyout;
        assign bank_rdata[i] = slv[i].hrdata;
        assign bank_resp[i]  = slv[i].hresp;
    end

    // one-hot select to index
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_sel[i]) begin
                sel_idx = bank_idx_t'(i);
            end
        end
    end

    // data phase owner
    always_ff @(posedge hclk) begin
        if (reset) begin
            owner_idx <= '0;
        end else if (addr_phase && !unmapped_sel) begin
            owner_idx <= sel_idx;           // idle keeps old owner, it answers okay
        end
    end

    // default slave
    always_comb begin
        err_next = err_state;
        case (err_state)
            ERR_IDLE:   if (addr_phase && unmapped_sel) err_next = ERR_FIRST;
            ERR_FIRST:  err_next = ERR_SECOND;      // no accept while hready low
            ERR_SECOND: err_next = (addr_phase && unmapped_sel) ? ERR_FIRST : ERR_IDLE;
            default:    err_next = ERR_IDLE;
        endcase
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            err_state <= ERR_IDLE;
        end else begin
            err_state <= err_next;
        end
    end

    assign err_owner = (err_state != ERR_IDLE);

    assign hready = err_owner ? (err_state == ERR_SECOND) : bank_ready[owner_idx];
    assign hresp  = err_owner ? HRESP_ERROR : bank_resp[owner_idx];
    assign hrdata = err_owner ? '0 : bank_rdata[owner_idx]; // error returns zeros

endmodule : ahb_resp_mux

//--- design/ahb_ram_sys.sv
`timescale 1ns/1ps

module ahb_ram_sys (
    input  logic            hclk,           // bus clock
    input  logic            reset,          // sync, active high
    input  logic [31:0]     haddr,          // byte address
    input  logic [31:0]     hwdata,         // write data
    input  logic            hwrite,         // 1 = write
    input  logic [1:0]      htrans,         // transfer type
    input  logic [2:0]      hsize,          // transfer size
    output logic [31:0]     hrdata,         // read data
    output logic            hready,         // transfer done
    output logic            hresp           // 0 okay, 1 error
);

    import ahb_pkg::*;
    import mem_map_pkg::*;

    logic       unmapped_sel;               // decoder -> mux
    logic       addr_phase;                 // decoder -> mux
    hresp_t     mux_hresp;                  // typed response from mux

    ahb_slave_if slv_bus [NUM_BANKS] ();    // one ahb bus per bank
    ram_port_if  ram_bus [NUM_BANKS] ();    // one ram port per bank

    ahb_addr_decoder u_decoder (
        .haddr        (haddr),
        .htrans       (htrans_t'(htrans)),
        .hwrite       (hwrite),
        .hsize        (hsize_t'(hsize)),
        .hwdata       (hwdata),
        .hready       (hready),             // loops back from mux, registered source
        .slv          (slv_bus),
        .unmapped_sel (unmapped_sel),
        .addr_phase   (addr_phase)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        ahb_ram_bridge u_bridge (
            .hclk  (hclk),
            .reset (reset),
            .slv   (slv_bus[i]),
            .ram   (ram_bus[i])
        );

        ram_bank_mem u_mem (
            .hclk  (hclk),
            .ram   (ram_bus[i])
        );
    end

    ahb_resp_mux u_resp_mux (
        .hclk         (hclk),
        .reset        (reset),
        .slv          (slv_bus),
        .unmapped_sel (unmapped_sel),
        .addr_phase   (addr_phase),
        .hrdata       (hrdata),
        .hready       (hready),
        .hresp        (mux_hresp)
    );

    assign hresp = (mux_hresp == HRESP_ERROR); // enum to plain port bit

endmodule : ahb_ram_sys

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic hclk                       // bus clock
);

    initial begin
        hclk = 1'b0;
        forever #20 hclk = ~hclk;           // 40 ns period
    end

endmodule : tb_clock_gen

//--- tb/ahb_ram_sys_assert.sv
`timescale 1ns/1ps

module ahb_ram_sys_assert (
    input  logic            hclk,           // bus clock
    input  logic            reset,          // sync, active high
    input  logic [31:0]     haddr,
    input  logic [31:0]     hwdata,
    input  logic            hwrite,
    input  logic [1:0]      htrans,
    input  logic [2:0]      hsize,
    input  logic [31:0]     hrdata,
    input  logic            hready,
    input  logic            hresp
);

    import ahb_pkg::*;
    import mem_map_pkg::*;

    bit             assert_failed = 1'b0;                   // sticky, seen by the testbench
    logic [7:0]     ref_mem [NUM_BANKS*BANK_WORDS*4];       // byte model of mapped space
    logic [NUM_BANKS*BANK_WORDS*4-1:0] ref_known;           // byte written at least once
    logic           accept;                 // address phase taken this edge
    logic           unmapped;
    logic           dp_valid;               // transfer in data phase
    logic           dp_write;
    logic [31:0]    dp_addr;
    logic [2:0]     dp_size;
    logic           dp_mapped;
    logic [3:0]     dp_lanes;               // lanes the transfer touches
    logic           rd_check;               // mapped read in data phase
    logic [31:0]    exp_word;
    logic [31:0]    exp_mask;               // only bytes with known contents
    err_state_t     exp_err;                // expected default slave sequence

    // lanes by size, low address bits pick the position
    function automatic logic [3:0] size_lanes(input logic [2:0] size, input logic [1:0] a);
        case (size)
            HSIZE_B:  size_lanes = 4'b0001 << a;
            HSIZE_HW: size_lanes = 4'b0011 << {a[1], 1'b0};
            default:  size_lanes = 4'b1111;
        endcase
    endfunction

    assign accept    = hready && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));
    assign unmapped  = (haddr >= MAP_LIMIT);
    assign dp_mapped = (dp_addr < MAP_LIMIT);
    assign dp_lanes  = size_lanes(dp_size, dp_addr[1:0]);
    assign rd_check  = dp_valid && !dp_write && dp_mapped;

    // data phase tracking and model update when a write phase closes
    always_ff @(posedge hclk) begin
        if (reset) begin
            dp_valid  <= 1'b0;
            dp_write  <= 1'b0;
            dp_addr   <= '0;
            dp_size   <= '0;
            ref_known <= '0;
        end else if (hready) begin
            if (dp_valid && dp_write && dp_mapped) begin
                for (int b = 0; b < 4; b++) begin
                    if (dp_lanes[b]) begin
                        ref_mem[{dp_addr[11:2], b[1:0]}]   <= hwdata[8*b +: 8];
                        ref_known[{dp_addr[11:2], b[1:0]}] <= 1'b1;
                    end
                end
            end
            dp_valid <= accept;
            dp_write <= hwrite;
            dp_addr  <= haddr;
            dp_size  <= hsize;
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            exp_word[8*b +: 8] = ref_mem[{dp_addr[11:2], b[1:0]}];
            exp_mask[8*b +: 8] = {8{ref_known[{dp_addr[11:2], b[1:0]}]}};
        end
    end

    // two cycle error response for every unmapped transfer
    always_ff @(posedge hclk) begin
        if (reset) begin
            exp_err <= ERR_IDLE;
        end else if (exp_err == ERR_FIRST) begin
            exp_err <= ERR_SECOND;
        end else begin
            exp_err <= (accept && unmapped) ? ERR_FIRST : ERR_IDLE;
        end
    end

    a_reset_ready: assert property (@(posedge hclk) reset |=> (hready && !hresp))
        else begin
            assert_failed = 1'b1;
            $error("ERROR after reset hready %h hresp %h, expected 1 and 0",
                   $sampled(hready), $sampled(hresp));
        end

    a_zero_wait_okay: assert property (@(posedge hclk) disable iff (reset)
            (exp_err == ERR_IDLE) |-> (hready && !hresp))
        else begin
            assert_failed = 1'b1;
            $error("ERROR hready/hresp expected 1/0 got %h/%h",
                   $sampled(hready), $sampled(hresp));
        end

    a_error_first: assert property (@(posedge hclk) disable iff (reset)
            (exp_err == ERR_FIRST) |-> (!hready && hresp))
        else begin
            assert_failed = 1'b1;
            $error("ERROR first error cycle hready/hresp expected 0/1 got %h/%h",
                   $sampled(hready), $sampled(hresp));
        end

    a_error_second: assert property (@(posedge hclk) disable iff (reset)
            (exp_err == ERR_SECOND) |-> (hready && hresp))
        else begin
            assert_failed = 1'b1;
            $error("ERROR second error cycle hready/hresp expected 1/1 got %h/%h",
                   $sampled(hready), $sampled(hresp));
        end

    a_read_data: assert property (@(posedge hclk) disable iff (reset)
            (hready && rd_check) |-> (((hrdata ^ exp_word) & exp_mask) == 32'h0))
        else begin
            assert_failed = 1'b1;
            $error("ERROR hrdata at %h expected %h got %h (mask %h)", $sampled(dp_addr),
                   $sampled(exp_word & exp_mask), $sampled(hrdata & exp_mask),
                   $sampled(exp_mask));
        end

endmodule : ahb_ram_sys_assert

//--- tb/ahb_ram_sys_tb.sv
`timescale 1ns/1ps

module ahb_ram_sys_tb;

    import ahb_pkg::*;
    import mem_map_pkg::*;

    localparam int N_RAND     = 200;                        // random back-to-back transfers
    localparam int N_XFERS    = 94 + N_RAND;                // all bus transfers of the run
    localparam int TIMEOUT_NS = 2 * N_XFERS * 3 * 40 + 10 * 40;

    logic           hclk;
    logic           reset;
    logic [31:0]    haddr;
    logic [31:0]    hwdata;
    logic           hwrite;
    logic [1:0]     htrans;
    logic [2:0]     hsize;
    logic [31:0]    hrdata;
    logic           hready;
    logic           hresp;
    logic [31:0]    data_q;                 // write data for the open data phase
    int             seed = 32'he188_9181;

    tb_clock_gen u_clk (
        .hclk (hclk)
    );

    ahb_ram_sys uut (
        .hclk   (hclk),
        .reset  (reset),
        .haddr  (haddr),
        .hwdata (hwdata),
        .hwrite (hwrite),
        .htrans (htrans),
        .hsize  (hsize),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp)
    );

    bind ahb_ram_sys ahb_ram_sys_assert u_checks (.*);

    // drives one address phase along with the previous transfer's write data
    task automatic drive_transfer(input logic [31:0] addr, input logic write,
                                  input logic [2:0] size, input logic [1:0] trans,
                                  input logic [31:0] wdata);
        haddr  <= addr;
        hwrite <= write;
        hsize  <= size;
        htrans <= trans;
        hwdata <= data_q;
        @(negedge hclk);                    // hready settled mid cycle
        while (!hready) begin
            @(negedge hclk);                // held through wait states
        end
        @(posedge hclk);                    // address phase taken here
        data_q = wdata;
    endtask

    task automatic write_access(input logic [31:0] addr, input logic [2:0] size,
                                input logic [31:0] wdata);
        drive_transfer(addr, 1'b1, size, HTRANS_NONSEQ, wdata);
    endtask

    task automatic read_access(input logic [31:0] addr);
        drive_transfer(addr, 1'b0, HSIZE_W, HTRANS_NONSEQ, 32'h0);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] base;
        logic [2:0]  size;
        reset  = 1'b1;
        haddr  = '0;
        hwdata = '0;
        hwrite = 1'b0;
        htrans = HTRANS_IDLE;
        hsize  = HSIZE_W;
        data_q = '0;
        repeat (10) @(posedge hclk);
        reset <= 1'b0;

        // idle and busy cycles with some addresses in unmapped space
        drive_transfer(32'h0, 1'b0, HSIZE_W, HTRANS_IDLE, 32'h0);
        drive_transfer(MAP_LIMIT, 1'b1, HSIZE_W, HTRANS_IDLE, 32'h0);
        drive_transfer(MAP_LIMIT + 32'h4, 1'b0, HSIZE_W, HTRANS_BUSY, 32'h0);
        drive_transfer(32'h4, 1'b1, HSIZE_W, HTRANS_BUSY, 32'h0);

        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < 4; w++) begin
                write_access(32'((b << BANK_SEL_LSB) + w * 4), HSIZE_W, $random(seed));
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < 4; w++) begin
                read_access(32'((b << BANK_SEL_LSB) + w * 4));
            end
        end

        // byte and halfword lanes merged into word 4 of each bank
        for (int b = 0; b < NUM_BANKS; b++) begin
            base = 32'((b << BANK_SEL_LSB) + 16);
            for (int k = 0; k < 4; k++) begin
                write_access(base + 32'(k), HSIZE_B, $random(seed));
            end
            read_access(base);
            write_access(base, HSIZE_HW, $random(seed));
            read_access(base);
            write_access(base + 32'h2, HSIZE_HW, $random(seed));
            read_access(base);
        end

        for (int b = 0; b < NUM_BANKS; b++) begin
            write_access(32'((b << BANK_SEL_LSB) + 20), HSIZE_W, $random(seed));
            read_access(32'((b << BANK_SEL_LSB) + 20));     // same word right away
        end

        // unmapped write and read back to back before the aliased bank word
        for (int b = 0; b < NUM_BANKS; b++) begin
            write_access(MAP_LIMIT + 32'(b << BANK_SEL_LSB), HSIZE_W, $random(seed));
            read_access(MAP_LIMIT + 32'(b << BANK_SEL_LSB));
            read_access(32'(b << BANK_SEL_LSB));
        end

        for (int i = 0; i < N_RAND; i++) begin
            r    = $random(seed);
            addr = {20'h0, r[11:10], 5'h0, r[4:0]};         // words 0..7 of a bank
            case (r[6:5])
                2'b00:   size = HSIZE_B;
                2'b01:   size = HSIZE_HW;
                default: size = HSIZE_W;
            endcase
            if (size == HSIZE_HW) begin
                addr[0] = 1'b0;
            end
            if (size == HSIZE_W) begin
                addr[1:0] = 2'b00;
            end
            drive_transfer(addr, r[7], size, r[8] ? HTRANS_SEQ : HTRANS_NONSEQ,
                           $random(seed));
        end

        drive_transfer(32'h0, 1'b0, HSIZE_W, HTRANS_IDLE, 32'h0);  // closes last data phase
        drive_transfer(32'h0, 1'b0, HSIZE_W, HTRANS_IDLE, 32'h0);
        @(negedge hclk);
        if (!uut.u_checks.assert_failed) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "assertion failure during the run");
        end
    end

    always @(posedge hclk) begin
        if (uut.u_checks.assert_failed) begin
            $display("Simulation FAILED");
            $fatal(1, "assertion failure during the run");
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: transfers did not complete");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule : ahb_ram_sys_tb

//--- filelist.f
common/ahb_pkg.sv
common/mem_map_pkg.sv
common/ahb_slave_if.sv
common/ram_port_if.sv
design/ahb_addr_decoder.sv
ahb_ram/ahb_ram_bridge.sv
ahb_ram/ram_bank_mem.sv
design/ahb_resp_mux.sv
design/ahb_ram_sys.sv
tb/tb_clock_gen.sv
tb/ahb_ram_sys_assert.sv
tb/ahb_ram_sys_tb.sv

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the ahb ram subsystem testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
        --top-module ahb_ram_sys_tb -f filelist.f -o ahb_ram_sys_sim; then
    echo "verilator build failed"
    exit 1
fi

# keep running past the first assertion so the testbench reports it
if ! ./obj_dir/ahb_ram_sys_sim +verilator+error+limit+100 > "$LOG" 2>&1; then
    echo "simulation exited with an error status"
fi
cat "$LOG"

if grep -q "^Simulation PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
